// ==== rtl/decoder.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module decoder
  import rv_isa_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                fetcher_valid,
  input  logic [`FE_XLEN-1:0] instr,
  input  logic [`FE_XLEN-1:0] fetcher_pc,
  input  logic                exec_ready,
  output logic                decoder_ready,
  output logic [`FE_XLEN-1:0] next_pc,
  output logic                decode_valid,
  output op_class_t           op_class,
  output logic [4:0]          rd,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [2:0]          funct3,
  output logic [`FE_XLEN-1:0] imm,
  output logic [`FE_XLEN-1:0] decode_pc,
  output logic [`FE_XLEN-1:0] decode_instr
);

  rv_opcode_t          opcode;
  op_class_t           cls;
  imm_fmt_t            fmt;
  logic [`FE_XLEN-1:0] imm_c;
  logic                handoff;

  assign opcode = rv_opcode_t'(instr[6:0]);

  // every listed opcode ends in 2'b11, so a word with other low bits
  // never matches and falls through as illegal
  always_comb begin
    cls = cls_illegal;
    fmt = fmt_none;
    case (opcode)
      opc_lui: begin
        cls = cls_lui;
        fmt = fmt_u;
      end
      opc_auipc: begin
        cls = cls_auipc;
        fmt = fmt_u;
      end
      opc_jal: begin
        cls = cls_jal;
        fmt = fmt_j;
      end
      opc_jalr: begin
        cls = cls_jalr;
        fmt = fmt_i;
      end
      opc_branch: begin
        cls = cls_branch;
        fmt = fmt_b;
      end
      opc_load: begin
        cls = cls_load;
        fmt = fmt_i;
      end
      opc_store: begin
        cls = cls_store;
        fmt = fmt_s;
      end
      opc_op_imm: begin
        cls = cls_alu_imm;
        fmt = fmt_i;
      end
      opc_op: begin
        cls = cls_alu_reg;
        fmt = fmt_none;
      end
      opc_system: begin
        cls = cls_system;
        fmt = fmt_i;
      end
      default: begin
        cls = cls_illegal;
        fmt = fmt_none;
      end
    endcase
  end

  // for jal the format is fmt_j, so imm_c is also the jump offset
  imm_gen imm_gen_inst (
    .instr (instr),
    .fmt   (fmt),
    .imm   (imm_c)
  );

  assign next_pc = (cls == cls_jal) ? fetcher_pc + imm_c : fetcher_pc + 32'd4;

  // output stage is free when empty or being drained this cycle
  assign decoder_ready = !decode_valid || exec_ready;
  assign handoff       = fetcher_valid && decoder_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      decode_valid <= 1'b0;
    end else if (handoff) begin
      decode_valid <= 1'b1;
    end else if (exec_ready) begin
      decode_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (handoff) begin
      op_class     <= cls;
      rd           <= instr[11:7];
      rs1          <= instr[19:15];
      rs2          <= instr[24:20];
      funct3       <= instr[14:12];
      imm          <= imm_c;
      decode_pc    <= fetcher_pc;
      decode_instr <= instr;
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (reset)
    decode_valid && !exec_ready |=>
      decode_valid && $stable(op_class) && $stable(rd) && $stable(rs1) &&
      $stable(rs2) && $stable(funct3) && $stable(imm) &&
      $stable(decode_pc) && $stable(decode_instr));

endmodule

// ==== rtl/fetcher.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module fetcher
  import frontend_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                decoder_ready,
  input  logic [`FE_XLEN-1:0] next_pc,
  input  logic                mem_valid,
  input  logic [`FE_XLEN-1:0] mem_rdata,
  output logic                fetcher_valid,
  output logic [`FE_XLEN-1:0] instr,
  output logic [`FE_XLEN-1:0] fetcher_pc,
  output logic                mem_ready,
  output logic                mem_instr,
  output logic [`FE_XLEN-1:0] mem_addr,
  output logic [3:0]          mem_wstrb
);

  fetch_state_t        state;
  logic [`FE_XLEN-1:0] pc;
  logic                handoff;

  assign fetcher_valid = (state == st_hold);
  assign handoff       = fetcher_valid && decoder_ready;

  // pc only moves at a handoff, which is also when a new request leaves
  assign mem_addr   = pc;
  assign fetcher_pc = pc;

  // instruction reads only
  assign mem_instr = 1'b1;
  assign mem_wstrb = 4'b0000;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_request;
      pc        <= `FE_RESET_VECTOR;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= 1'b0;
      case (state)
        st_request: begin
          mem_ready <= 1'b1;
          state     <= st_wait;
        end
        st_wait: begin
          if (mem_valid) begin
            state <= st_hold;
          end
        end
        st_hold: begin
          // next request goes out together with the handoff
          if (handoff) begin
            pc        <= next_pc;
            mem_ready <= 1'b1;
            state     <= st_wait;
          end
        end
        default: begin
          state <= st_request;
        end
      endcase
    end
  end

  // capture the answer
  always_ff @(posedge clk) begin
    if (state == st_wait && mem_valid) begin
      instr <= mem_rdata;
    end
  end

  a_req_single_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_ready |=> !mem_ready);

  a_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
    mem_valid |-> state == st_wait);

  // word held toward the decoder until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    fetcher_valid && !decoder_ready |=>
      fetcher_valid && $stable(instr) && $stable(fetcher_pc));

endmodule

// ==== rtl/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// first fetch address after reset
`define FE_RESET_VECTOR 32'h0000_0000

// width of instructions, pc and immediates
`define FE_XLEN 32

// byte address bits decoded by the testbench memory
`define FE_MEM_AW 10

`endif

// ==== rtl/frontend_pkg.sv ====
package frontend_pkg;

  // fetcher states
  // st_request sends the first pulse after reset
  // st_wait waits for the memory answer
  // st_hold presents the word to the decoder
  typedef enum logic [1:0] {
    st_request,
    st_wait,
    st_hold
  } fetch_state_t;

endpackage

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module imm_gen
  import rv_isa_pkg::*;
(
  input  logic [`FE_XLEN-1:0] instr,
  input  imm_fmt_t            fmt,
  output logic [`FE_XLEN-1:0] imm
);

  always_comb begin
    case (fmt)
      fmt_i: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      fmt_s: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      // branch offsets are in halfwords so bit 0 is always zero
      fmt_b: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      fmt_u: begin
        imm = {instr[31:12], 12'b0};
      end
      fmt_j: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== rtl/instr_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module instr_frontend
  import rv_isa_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                mem_valid,
  input  logic [`FE_XLEN-1:0] mem_rdata,
  output logic                mem_ready,
  output logic                mem_instr,
  output logic [`FE_XLEN-1:0] mem_addr,
  output logic [3:0]          mem_wstrb,
  input  logic                exec_ready,
  output logic                decode_valid,
  output op_class_t           op_class,
  output logic [4:0]          rd,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [2:0]          funct3,
  output logic [`FE_XLEN-1:0] imm,
  output logic [`FE_XLEN-1:0] decode_pc,
  output logic [`FE_XLEN-1:0] decode_instr
);

  // fetch handoff between the two stages
  logic                fetcher_valid;
  logic                decoder_ready;
  logic [`FE_XLEN-1:0] instr;
  logic [`FE_XLEN-1:0] fetcher_pc;
  logic [`FE_XLEN-1:0] next_pc;

  fetcher fetcher_inst (
    .clk           (clk),
    .reset         (reset),
    .decoder_ready (decoder_ready),
    .next_pc       (next_pc),
    .mem_valid     (mem_valid),
    .mem_rdata     (mem_rdata),
    .fetcher_valid (fetcher_valid),
    .instr         (instr),
    .fetcher_pc    (fetcher_pc),
    .mem_ready     (mem_ready),
    .mem_instr     (mem_instr),
    .mem_addr      (mem_addr),
    .mem_wstrb     (mem_wstrb)
  );

  decoder decoder_inst (
    .clk           (clk),
    .reset         (reset),
    .fetcher_valid (fetcher_valid),
    .instr         (instr),
    .fetcher_pc    (fetcher_pc),
    .exec_ready    (exec_ready),
    .decoder_ready (decoder_ready),
    .next_pc       (next_pc),
    .decode_valid  (decode_valid),
    .op_class      (op_class),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .funct3        (funct3),
    .imm           (imm),
    .decode_pc     (decode_pc),
    .decode_instr  (decode_instr)
  );

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // RV32I major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } rv_opcode_t;

  // operation class handed to execute
  typedef enum logic [3:0] {
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu_imm,
    cls_alu_reg,
    cls_system,
    cls_illegal
  } op_class_t;

  typedef enum logic [2:0] {
    fmt_i,
    fmt_s,
    fmt_b,
    fmt_u,
    fmt_j,
    fmt_none
  } imm_fmt_t;

endpackage

// ==== verif/tb_instr_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_params.svh"

module tb_instr_frontend
  import rv_isa_pkg::*;
();

  localparam int NUM_TRANSFERS = 300;
  localparam int WATCHDOG_NS   = NUM_TRANSFERS * 12 * 10 + 1000;
  localparam int T_RESET  = 0;
  localparam int T_FETCH  = 1;
  localparam int T_FIELDS = 2;
  localparam int T_IMM    = 3;
  localparam int T_BP     = 4;
  localparam int T_PROTO  = 5;

  logic        clk;
  logic        reset;
  logic        mem_valid;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        mem_instr;
  logic [31:0] mem_addr;
  logic [3:0]  mem_wstrb;
  logic        exec_ready;
  logic        decode_valid;
  op_class_t   op_class;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  funct3;
  logic [31:0] imm;
  logic [31:0] decode_pc;
  logic [31:0] decode_instr;

  integer      seed = 9910;
  logic [31:0] mem [0:255];
  logic [6:0]  valid_ops [0:8] = '{7'b0110111, 7'b0010111, 7'b1100111,
                                   7'b1100011, 7'b0000011, 7'b0100011,
                                   7'b0010011, 7'b0110011, 7'b1110011};
  logic [31:0] exp_instr_q[$];
  logic [31:0] exp_pc_q[$];
  logic [31:0] model_pc;
  logic [31:0] fetched;
  integer      errors [0:5];
  integer      transfer_count;
  integer      req_count;
  integer      neg_imm_count;
  integer      held_cycles;
  integer      total_errors;
  logic        outstanding;
  logic        hold_pending;
  logic [117:0] held_bundle;
  logic        resp_pending;
  integer      resp_cnt;
  logic [7:0]  resp_idx;

  instr_frontend instr_frontend_inst (
    .clk          (clk),
    .reset        (reset),
    .mem_valid    (mem_valid),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .mem_instr    (mem_instr),
    .mem_addr     (mem_addr),
    .mem_wstrb    (mem_wstrb),
    .exec_ready   (exec_ready),
    .decode_valid (decode_valid),
    .op_class     (op_class),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .funct3       (funct3),
    .imm          (imm),
    .decode_pc    (decode_pc),
    .decode_instr (decode_instr)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // J-type offset, as the ISA manual lays out the bits
  function automatic logic [31:0] j_offset(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic op_class_t model_class(input logic [31:0] w);
    case (w[6:0])
      7'b0110111: return cls_lui;
      7'b0010111: return cls_auipc;
      7'b1101111: return cls_jal;
      7'b1100111: return cls_jalr;
      7'b1100011: return cls_branch;
      7'b0000011: return cls_load;
      7'b0100011: return cls_store;
      7'b0010011: return cls_alu_imm;
      7'b0110011: return cls_alu_reg;
      7'b1110011: return cls_system;
      default:    return cls_illegal;
    endcase
  endfunction

  function automatic logic [31:0] model_imm(input logic [31:0] w);
    case (w[6:0])
      7'b0110111, 7'b0010111: return {w[31:12], 12'b0};
      7'b1101111: return j_offset(w);
      7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: return {{20{w[31]}}, w[31:20]};
      7'b1100011: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
      default:    return 32'h0;
    endcase
  endfunction

  // random words patched into jal (1 in 8), illegal (1 in 20) or another valid opcode
  task automatic build_program;
    integer      i;
    integer      sel;
    integer      t;
    logic [31:0] w;
    logic [20:0] off;
    for (i = 0; i < 256; i++) begin
      w   = $random(seed);
      sel = {$random(seed)} % 40;
      if (sel < 5) begin
        // target word chosen first so the jump stays inside the 1 KB space
        t        = {$random(seed)} % 256;
        off      = t * 4 - i * 4;
        w[31]    = off[20];
        w[30:21] = off[10:1];
        w[20]    = off[11];
        w[19:12] = off[19:12];
        w[6:0]   = 7'b1101111;
      end else if (sel == 5) begin
        w[1:0] = 2'b00;
      end else if (sel == 6) begin
        w[6:0] = 7'b0001011;
      end else begin
        w[6:0] = valid_ops[{$random(seed)} % 9];
      end
      mem[i] = w;
    end
  endtask

  task automatic flag_error(input integer test_id, input string msg);
    errors[test_id] = errors[test_id] + 1;
    $display("error %0d ns: %s", $time, msg);
  endtask

  task automatic check_idle;
    if (mem_ready !== 1'b0 || decode_valid !== 1'b0) begin
      flag_error(T_RESET, "mem_ready or decode_valid high around reset");
    end
  endtask

  task automatic report_test(input integer test_id, input string name);
    if (errors[test_id] == 0) begin
      $display("test %0d %s: ok", test_id, name);
    end else begin
      $display("test %0d %s: %0d errors", test_id, name, errors[test_id]);
    end
  endtask

  task automatic check_transfer;
    logic [31:0] w;
    logic [31:0] p;
    logic [31:0] exp_imm;
    if (exp_instr_q.size() == 0) begin
      flag_error(T_BP, "transfer arrived with no fetched word pending");
    end else begin
      w       = exp_instr_q.pop_front();
      p       = exp_pc_q.pop_front();
      exp_imm = model_imm(w);
      if (decode_pc !== p || decode_instr !== w) begin
        flag_error(T_FIELDS, $sformatf("transfer pc %h instr %h, expected pc %h instr %h",
                                       decode_pc, decode_instr, p, w));
      end
      if (op_class !== model_class(w)) begin
        flag_error(T_FIELDS, $sformatf("op_class %0d, expected %0d for %h",
                                       op_class, model_class(w), w));
      end
      if (rd !== w[11:7] || rs1 !== w[19:15] || rs2 !== w[24:20] || funct3 !== w[14:12]) begin
        flag_error(T_FIELDS, $sformatf("register or funct3 fields wrong for %h", w));
      end
      if (imm !== exp_imm) begin
        flag_error(T_IMM, $sformatf("imm %h, expected %h for %h", imm, exp_imm, w));
      end
      if (exp_imm[31]) begin
        neg_imm_count = neg_imm_count + 1;
      end
    end
    transfer_count = transfer_count + 1;
  endtask

  // memory responder and execute back-pressure
  always @(posedge clk) begin
    if (reset) begin
      mem_valid    <= 1'b0;
      exec_ready   <= 1'b0;
      resp_pending = 1'b0;
    end else begin
      mem_valid  <= 1'b0;
      exec_ready <= ({$random(seed)} % 10) < 7;
      if (mem_ready) begin
        resp_pending = 1'b1;
        resp_idx     = mem_addr[`FE_MEM_AW-1:2];
        resp_cnt     = {$random(seed)} % 3;
      end
      if (resp_pending) begin
        if (resp_cnt == 0) begin
          mem_valid    <= 1'b1;
          mem_rdata    <= mem[resp_idx];
          resp_pending = 1'b0;
        end else begin
          resp_cnt = resp_cnt - 1;
        end
      end
    end
  end

  // reference model and monitor
  always @(posedge clk) begin
    if (!reset) begin
      if (mem_valid) begin
        outstanding = 1'b0;
      end
      if (mem_ready) begin
        if (outstanding) begin
          flag_error(T_PROTO, "mem_ready pulsed again before mem_valid");
        end
        if (req_count == 0 && mem_addr !== `FE_RESET_VECTOR) begin
          flag_error(T_RESET, $sformatf("first request at %h, not the reset vector", mem_addr));
        end
        if (mem_addr !== model_pc) begin
          flag_error(T_FETCH, $sformatf("request address %h, expected %h", mem_addr, model_pc));
        end
        if (mem_instr !== 1'b1 || mem_wstrb !== 4'b0000) begin
          flag_error(T_FETCH, "request is not a plain instruction read");
        end
        fetched = mem[model_pc[`FE_MEM_AW-1:2]];
        exp_instr_q.push_back(fetched);
        exp_pc_q.push_back(model_pc);
        if (fetched[6:0] == 7'b1101111) begin
          model_pc = model_pc + j_offset(fetched);
        end else begin
          model_pc = model_pc + 32'd4;
        end
        outstanding = 1'b1;
        req_count   = req_count + 1;
      end
      if (hold_pending) begin
        held_cycles = held_cycles + 1;
        if (!decode_valid || {op_class, rd, rs1, rs2, funct3, imm, decode_pc, decode_instr}
            !== held_bundle) begin
          flag_error(T_BP, "decoded outputs changed while exec_ready was low");
        end
      end
      hold_pending = decode_valid && !exec_ready;
      held_bundle  = {op_class, rd, rs1, rs2, funct3, imm, decode_pc, decode_instr};
      if (decode_valid && exec_ready) begin
        check_transfer();
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d transfers completed", transfer_count, NUM_TRANSFERS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    reset          = 1'b1;
    mem_rdata      = 32'h0;
    exec_ready     = 1'b0;
    mem_valid      = 1'b0;
    model_pc       = `FE_RESET_VECTOR;
    transfer_count = 0;
    req_count      = 0;
    neg_imm_count  = 0;
    held_cycles    = 0;
    outstanding    = 1'b0;
    hold_pending   = 1'b0;
    for (int i = 0; i < 6; i++) begin
      errors[i] = 0;
    end
    build_program();
    @(posedge clk);
    @(posedge clk);
    check_idle();
    @(posedge clk);
    check_idle();
    reset <= 1'b0;
    @(posedge clk);
    check_idle();
    wait (req_count > 0);
    report_test(T_RESET, "reset");
    wait (transfer_count >= NUM_TRANSFERS);
    if (neg_imm_count == 0) begin
      errors[T_IMM] = errors[T_IMM] + 1;
      $display("no negative immediate came through in %0d transfers", transfer_count);
    end
    // at most one word can be in flight behind the last transfer
    if (req_count < transfer_count || req_count > transfer_count + 1) begin
      errors[T_PROTO] = errors[T_PROTO] + 1;
      $display("%0d requests for %0d transfers, words were lost or duplicated",
               req_count, transfer_count);
    end
    report_test(T_FETCH, "fetch order");
    report_test(T_FIELDS, "decode fields");
    report_test(T_IMM, "immediates");
    report_test(T_BP, "back-pressure");
    report_test(T_PROTO, "protocol");
    total_errors = 0;
    for (int i = 0; i < 6; i++) begin
      total_errors = total_errors + errors[i];
    end
    $display("tests 6, requests %0d, transfers %0d, held cycles %0d, errors %0d",
             req_count, transfer_count, held_cycles, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/frontend_pkg.sv
rtl/imm_gen.sv
rtl/fetcher.sv
rtl/decoder.sv
rtl/instr_frontend.sv
verif/tb_instr_frontend.sv
